/* project.f */
src/combine_pkg.sv
src/line_wr_ctrl.sv
src/line_buf.sv
src/line_rd_ctrl.sv
src/combine_regs.sv
src/pixel_combine.sv
sim/combine_sva.sv
sim/combine_checker.sv
sim/tb_pixel_combine.sv

/* Makefile */
SIM      := verilator
TOP      := tb_pixel_combine
FILELIST := project.f
FLAGS    := --binary --timing --assert -Wno-fatal
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || { echo "Simulation ended early"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_pixel_combine.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pixel_combine;

    import combine_pkg::*;

    localparam int LINE_PIX = 64;
    localparam int PTR_W    = $clog2(LINE_PIX) + 1;
    localparam int N_TESTS  = 3;
    localparam int AHEAD_N  = 16;

    typedef struct packed {
        logic [15:0] line_len;
        logic [7:0]  lines;
        logic [7:0]  cam2_delay;
        logic [7:0]  gap;
    } test_t;

    // Line length, lines, camera 2 delay, href gap.
    test_t tests [N_TESTS] = '{
        '{16'd8,  8'd3, 8'd4, 8'd2},
        '{16'd16, 8'd2, 8'd0, 8'd5},
        '{16'd4,  8'd4, 8'd7, 8'd0}
    };

    logic             rclk     = 1'b0;
    logic             pclk_1   = 1'b0;
    logic             pclk_2   = 1'b0;
    logic             arst_n;
    logic             req      = 1'b0;
    host_req_t        host     = '0;
    logic             inited_1 = 1'b1;
    logic             inited_2 = 1'b1;
    logic             href_1   = 1'b0;
    logic             href_2   = 1'b0;
    pix_t             data_1   = '0;
    pix_t             data_2   = '0;
    logic             ack;
    reg_data_t        rdata;
    pix_pair_t        pair;
    logic             valid;
    logic             finish;
    logic [PTR_W-1:0] ahead;
    int               errors;
    int               seed = 32'h4dc2;
    reg_data_t        rd;
    reg_data_t        line_base [32];

    initial forever #5 rclk = ~rclk;
    initial forever #11.5 pclk_1 = ~pclk_1; // 23 ns.
    initial forever #14.5 pclk_2 = ~pclk_2; // 29 ns.

    pixel_combine #(.LINE_PIX(LINE_PIX)) DUT (.*);

    combine_checker chk (.*);

    task automatic host_access(input logic we, input reg_addr_t addr, input reg_data_t wdata);
        int n;
        @(posedge rclk);
        host <= {we, addr, wdata};
        req  <= 1'b1;
        n = 0;
        do begin
            @(posedge rclk);
            n++;
        end while (!ack && n < 20);
        if (!ack)
            chk.fail("host port never raised ack");
        rd = rdata;
        req <= 1'b0;
        n = 0;
        do begin
            @(posedge rclk);
            n++;
        end while (ack && n < 20);
        if (ack)
            chk.fail("host port left ack high after req dropped");
    endtask

    task automatic step_cam(input int cam, input logic hr, input pix_t d);
        if (cam == 1) begin
            @(posedge pclk_1);
            href_1 <= hr;
            data_1 <= d;
        end else begin
            @(posedge pclk_2);
            href_2 <= hr;
            data_2 <= d;
        end
    endtask

    task automatic stream_camera(input int cam, input int first, input test_t t, input int delay);
        repeat (delay) step_cam(cam, 1'b0, '0);
        for (int l = first; l < first + t.lines; l++) begin
            repeat (t.gap) step_cam(cam, 1'b0, '0);
            for (int k = 0; k < t.line_len; k++) begin
                step_cam(cam, 1'b1, chk.pixel_word(cam, l, line_base[l % 32] + k));
            end
        end
        step_cam(cam, 1'b0, '0);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (chk.pending() != 0 && n < 2000) begin
            @(posedge rclk);
            n++;
        end
        if (chk.pending() != 0)
            chk.fail("pixel pairs still missing at the drain timeout");
        repeat (8) @(posedge rclk); // Let ahead and line_cnt settle.
    endtask

    task automatic run_lines(input test_t t, input int first);
        for (int l = first; l < first + t.lines; l++) begin
            line_base[l % 32] = reg_data_t'($random(seed));
            chk.add_line(1, l, line_base[l % 32], t.line_len);
            chk.add_line(2, l, line_base[l % 32], t.line_len);
        end
        fork
            stream_camera(1, first, t, 0);
            stream_camera(2, first, t, t.cam2_delay);
        join
        wait_drain();
    endtask

    initial begin
        int    v0;
        test_t ahead_t;
        arst_n = 1'b0;
        repeat (4) @(posedge rclk);
        arst_n <= 1'b1;
        host_access(1'b1, REG_CTRL, 16'h0001);
        host_access(1'b0, REG_CTRL, '0);
        chk.expect_eq("ctrl readback", rd, 1);
        for (int i = 0; i < N_TESTS; i++) begin
            host_access(1'b1, REG_LINE_LEN, tests[i].line_len);
            host_access(1'b0, REG_LINE_LEN, '0);
            chk.expect_eq("line_len readback", rd, tests[i].line_len);
            host_access(1'b1, REG_LINE_CNT, '0);
            host_access(1'b0, REG_LINE_CNT, '0);
            chk.expect_eq("line_cnt after clear", rd, 0);
            chk.set_line_len(tests[i].line_len);
            run_lines(tests[i], i * 8);
            host_access(1'b0, REG_LINE_CNT, '0);
            chk.expect_eq("line_cnt", rd, tests[i].lines);
            chk.end_test("table row");
        end

        // Pixels sent while disabled never reach the buffers.
        host_access(1'b1, REG_CTRL, '0);
        repeat (10) @(posedge rclk);
        v0 = chk.valids;
        fork
            stream_camera(1, 16, tests[N_TESTS-1], 0);
            stream_camera(2, 16, tests[N_TESTS-1], 0);
        join
        repeat (12) @(posedge rclk);
        chk.expect_eq("valids while disabled", chk.valids, v0);
        host_access(1'b1, REG_CTRL, 16'h0001);
        repeat (10) @(posedge rclk);
        chk.end_test("enable cleared");

        // Camera 2 not inited, so camera 1 runs ahead.
        ahead_t = '{16'(AHEAD_N), 8'd1, 8'd0, 8'd0};
        @(posedge pclk_2);
        inited_2 <= 1'b0;
        host_access(1'b1, REG_LINE_CNT, '0);
        line_base[30] = reg_data_t'($random(seed));
        chk.add_line(1, 30, line_base[30], AHEAD_N);
        v0 = chk.valids;
        fork
            stream_camera(1, 30, ahead_t, 0);
            stream_camera(2, 30, ahead_t, 0);
        join
        repeat (12) @(posedge rclk);
        chk.expect_eq("valids with inited_2 low", chk.valids, v0);
        chk.expect_eq("ahead after quiet period", ahead, AHEAD_N);
        @(posedge pclk_2);
        inited_2 <= 1'b1;
        chk.add_line(2, 30, line_base[30], AHEAD_N);
        stream_camera(2, 30, ahead_t, 0);
        wait_drain();
        chk.expect_eq("ahead after catch-up", ahead, 0);
        host_access(1'b0, REG_LINE_CNT, '0);
        chk.expect_eq("line_cnt", rd, AHEAD_N / tests[N_TESTS-1].line_len);
        chk.end_test("camera 2 behind");

        chk.report();
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Slowest pixel clock, four times over, plus margin.
    initial begin
        longint limit;
        limit = 20000;
        for (int i = 0; i < N_TESTS; i++) begin
            limit += tests[i].lines * tests[i].line_len * 29 * 4;
        end
        limit += 3 * AHEAD_N * 29 * 4;
        #(limit);
        $display("Watchdog expired after %0d ns, the run did not complete", limit);
        $display("Done: errors found");
        $finish;
    end

endmodule : tb_pixel_combine

`default_nettype wire

/* sim/combine_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module combine_checker (
    input  logic                   rclk,
    input  logic                   valid,
    input  logic                   finish,
    input  combine_pkg::pix_pair_t pair,
    output int                     errors
);

    import combine_pkg::*;

    pix_t      q1 [$];
    pix_t      q2 [$];
    pix_pair_t expected;
    logic      exp_finish;
    int        line_len = 0;
    int        in_line  = 0;
    int        valids   = 0;
    int        pairs    = 0;
    int        tests    = 0;
    int        err_cnt  = 0;
    int        err_mark = 0;

    assign errors = err_cnt;

    // Camera in bit 15, line in 14:10, index below.
    function automatic pix_t pixel_word(input int cam, input int line, input int idx);
        return {cam == 2, line[4:0], idx[9:0]};
    endfunction

    task automatic add_line(input int cam, input int line, input int base, input int len);
        for (int k = 0; k < len; k++) begin
            if (cam == 1)
                q1.push_back(pixel_word(cam, line, base + k));
            else
                q2.push_back(pixel_word(cam, line, base + k));
        end
    endtask

    function automatic int pending();
        return q1.size() + q2.size();
    endfunction

    task automatic set_line_len(input int len);
        line_len = len;
    endtask

    task automatic expect_eq(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic fail(input string msg);
        $display("%0t: %s", $time, msg);
        err_cnt++;
    endtask

    // Outputs change on the rising edge.
    always @(negedge rclk) begin
        if (valid === 1'b1) begin
            valids++;
            if (q1.size() == 0 || q2.size() == 0) begin
                $display("%0t: valid came with no pixel pair pending", $time);
                err_cnt++;
            end else begin
                expected.pixel_1 = q1.pop_front();
                expected.pixel_2 = q2.pop_front();
                pairs++;
                in_line++;
                exp_finish = (line_len != 0) && (in_line == line_len);
                if (exp_finish)
                    in_line = 0;
                if (pair !== expected) begin
                    $display("MISMATCH at %0t: pair %h, expected %h", $time, pair, expected);
                    err_cnt++;
                end
                if (finish !== exp_finish) begin
                    $display("MISMATCH at %0t: finish %b, expected %b", $time, finish,
                             exp_finish);
                    err_cnt++;
                end
            end
        end else if (finish === 1'b1) begin
            $display("%0t: finish pulsed without valid", $time);
            err_cnt++;
        end
    end

    task automatic end_test(input string name);
        tests++;
        $display("test %0d (%s): %s, %0d pairs so far", tests, name,
                 (err_cnt == err_mark) ? "ok" : "FAILED", pairs);
        err_mark = err_cnt;
    endtask

    task automatic report();
        $display("%0d tests, %0d pairs, %0d errors", tests, pairs, err_cnt);
    endtask

endmodule : combine_checker

`default_nettype wire

/* sim/combine_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module combine_sva (
    input logic clk,
    input logic arst_n,
    input logic req,
    input logic ack,
    input logic enable,
    input logic valid,
    input logic finish
);

    // Ack drops only once req is gone.
    ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req was still high");

    finish_with_valid: assert property (@(posedge clk) disable iff (!arst_n)
        finish |-> valid)
        else $error("finish pulsed without valid");

    // Valid trails the read issue by one cycle.
    no_valid_disabled: assert property (@(posedge clk) disable iff (!arst_n)
        !$past(enable) |-> !valid)
        else $error("valid rose while enable was low");

endmodule : combine_sva

bind pixel_combine combine_sva u_sva (
    .clk   (rclk  ),
    .arst_n(arst_n),
    .req   (req   ),
    .ack   (ack   ),
    .enable(enable),
    .valid (valid ),
    .finish(finish)
);

`default_nettype wire

/* src/pixel_combine.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_combine #(
    parameter  int LINE_PIX = 1024,
    localparam int ADDR_W   = $clog2(LINE_PIX),
    localparam int PTR_W    = ADDR_W + 1
) (
    input  logic                   rclk,
    input  logic                   arst_n,
    input  logic                   req,
    input  combine_pkg::host_req_t host,
    output logic                   ack,
    output combine_pkg::reg_data_t rdata,

    input  logic                   pclk_1,
    input  logic                   inited_1,
    input  logic                   href_1,
    input  combine_pkg::pix_t      data_1,

    input  logic                   pclk_2,
    input  logic                   inited_2,
    input  logic                   href_2,
    input  combine_pkg::pix_t      data_2,

    output combine_pkg::pix_pair_t pair,
    output logic                   valid,
    output logic                   finish,
    output logic [PTR_W-1:0]       ahead
);

    import combine_pkg::*;

    logic              enable;
    reg_data_t         line_len;
    logic              wr_en_1;
    logic              wr_en_2;
    logic [ADDR_W-1:0] wr_addr_1;
    logic [ADDR_W-1:0] wr_addr_2;
    logic [PTR_W-1:0]  wr_ptr_gray_1;
    logic [PTR_W-1:0]  wr_ptr_gray_2;
    logic [ADDR_W-1:0] rd_addr;

    combine_regs u_regs (
        .rclk    (rclk    ),
        .arst_n  (arst_n  ),
        .req     (req     ),
        .host    (host    ),
        .ack     (ack     ),
        .rdata   (rdata   ),
        .finish  (finish  ),
        .enable  (enable  ),
        .line_len(line_len)
    );

    line_wr_ctrl #(.LINE_PIX(LINE_PIX)) u_cam1_wr (
        .pclk       (pclk_1       ),
        .arst_n     (arst_n       ),
        .enable     (enable       ),
        .inited     (inited_1     ),
        .href       (href_1       ),
        .wr_en      (wr_en_1      ),
        .wr_addr    (wr_addr_1    ),
        .wr_ptr_gray(wr_ptr_gray_1)
    );

    line_wr_ctrl #(.LINE_PIX(LINE_PIX)) u_cam2_wr (
        .pclk       (pclk_2       ),
        .arst_n     (arst_n       ),
        .enable     (enable       ),
        .inited     (inited_2     ),
        .href       (href_2       ),
        .wr_en      (wr_en_2      ),
        .wr_addr    (wr_addr_2    ),
        .wr_ptr_gray(wr_ptr_gray_2)
    );

    // Both buffers share one read address.
    line_buf #(.LINE_PIX(LINE_PIX)) u_cam1_buf (
        .wr_clk (pclk_1      ),
        .wr_en  (wr_en_1     ),
        .wr_addr(wr_addr_1   ),
        .wr_data(data_1      ),
        .rd_clk (rclk        ),
        .rd_addr(rd_addr     ),
        .rd_data(pair.pixel_1)
    );

    line_buf #(.LINE_PIX(LINE_PIX)) u_cam2_buf (
        .wr_clk (pclk_2      ),
        .wr_en  (wr_en_2     ),
        .wr_addr(wr_addr_2   ),
        .wr_data(data_2      ),
        .rd_clk (rclk        ),
        .rd_addr(rd_addr     ),
        .rd_data(pair.pixel_2)
    );

    line_rd_ctrl #(.LINE_PIX(LINE_PIX)) u_rd (
        .rclk         (rclk         ),
        .arst_n       (arst_n       ),
        .enable       (enable       ),
        .line_len     (line_len     ),
        .wr_ptr_gray_1(wr_ptr_gray_1),
        .wr_ptr_gray_2(wr_ptr_gray_2),
        .rd_addr      (rd_addr      ),
        .valid        (valid        ),
        .finish       (finish       ),
        .ahead        (ahead        )
    );

endmodule : pixel_combine

`default_nettype wire

/* src/combine_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module combine_regs (
    input  logic                   rclk,
    input  logic                   arst_n,
    input  logic                   req,
    input  combine_pkg::host_req_t host,
    output logic                   ack,
    output combine_pkg::reg_data_t rdata,
    input  logic                   finish,
    output logic                   enable,
    output combine_pkg::reg_data_t line_len
);

    import combine_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_DROP
    } hs_state_t;

    hs_state_t state;
    reg_data_t line_cnt;
    reg_data_t rd_mux;
    logic      access;
    logic      cnt_clr;

    assign access  = (state == IDLE) && req;
    assign cnt_clr = access && host.we && (host.addr == REG_LINE_CNT);

    always_comb begin
        case (host.addr)
            REG_CTRL:     rd_mux = {15'b0, enable};
            REG_LINE_LEN: rd_mux = line_len;
            REG_LINE_CNT: rd_mux = line_cnt;
            default:      rd_mux = '0;
        endcase
    end

    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            ack      <= 1'b0;
            enable   <= 1'b0;
            line_len <= '0;
        end else begin
            case (state)
                IDLE: if (req) begin
                    ack   <= 1'b1;
                    state <= ACK;
                    if (host.we && host.addr == REG_CTRL) enable <= host.wdata[0];
                    if (host.we && host.addr == REG_LINE_LEN) line_len <= host.wdata;
                end
                ACK: if (!req) begin
                    ack   <= 1'b0;
                    state <= WAIT_DROP;
                end
                default: state <= IDLE; // One idle cycle after ack drops.
            endcase
        end
    end

    // Valid with the rising ack.
    always_ff @(posedge rclk) begin
        if (access) begin
            rdata <= rd_mux;
        end
    end

    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            line_cnt <= '0;
        end else if (cnt_clr) begin
            line_cnt <= '0;
        end else if (finish) begin
            line_cnt <= line_cnt + 1'b1;
        end
    end

endmodule : combine_regs

`default_nettype wire

/* src/line_rd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module line_rd_ctrl #(
    parameter  int LINE_PIX = 1024,
    localparam int ADDR_W   = $clog2(LINE_PIX),
    localparam int PTR_W    = ADDR_W + 1
) (
    input  logic                   rclk,
    input  logic                   arst_n,
    input  logic                   enable,
    input  combine_pkg::reg_data_t line_len,
    input  logic [PTR_W-1:0]       wr_ptr_gray_1,
    input  logic [PTR_W-1:0]       wr_ptr_gray_2,
    output logic [ADDR_W-1:0]      rd_addr,
    output logic                   valid,
    output logic                   finish,
    output logic [PTR_W-1:0]       ahead
);

    import combine_pkg::*;

    logic [1:0][PTR_W-1:0] gray_meta;
    logic [1:0][PTR_W-1:0] gray_sync;
    logic [PTR_W-1:0]      wr_bin_1;
    logic [PTR_W-1:0]      wr_bin_2;
    logic [PTR_W-1:0]      fill_1;
    logic [PTR_W-1:0]      fill_2;
    logic [PTR_W-1:0]      rd_ptr;
    logic                  rd_issue;
    logic                  line_last;
    reg_data_t             pix_cnt;
    reg_data_t             cnt_next;

    function automatic logic [PTR_W-1:0] gray2bin(input logic [PTR_W-1:0] g);
        logic [PTR_W-1:0] b;
        b[PTR_W-1] = g[PTR_W-1];
        for (int i = PTR_W - 2; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // Two flops per pointer, both cameras at once.
    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            gray_meta <= '0;
            gray_sync <= '0;
        end else begin
            gray_meta <= {wr_ptr_gray_2, wr_ptr_gray_1};
            gray_sync <= gray_meta;
        end
    end

    assign wr_bin_1 = gray2bin(gray_sync[0]);
    assign wr_bin_2 = gray2bin(gray_sync[1]);
    assign fill_1   = wr_bin_1 - rd_ptr;
    assign fill_2   = wr_bin_2 - rd_ptr;

    // Read only when both cameras have an unread pixel.
    assign rd_issue  = enable && (fill_1 != '0) && (fill_2 != '0);
    assign rd_addr   = rd_ptr[ADDR_W-1:0];
    assign cnt_next  = pix_cnt + 1'b1;
    assign line_last = (line_len != '0) && (cnt_next >= line_len);

    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr  <= '0;
            pix_cnt <= '0;
            valid   <= 1'b0;
            finish  <= 1'b0;
        end else begin
            valid  <= rd_issue;             // Data lands next cycle.
            finish <= rd_issue && line_last;
            if (rd_issue) begin
                rd_ptr  <= rd_ptr + 1'b1;
                pix_cnt <= line_last ? '0 : cnt_next;
            end
        end
    end

    // Lead of the faster camera.
    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            ahead <= '0;
        end else if (fill_1 >= fill_2) begin
            ahead <= fill_1 - fill_2;
        end else begin
            ahead <= fill_2 - fill_1;
        end
    end

endmodule : line_rd_ctrl

`default_nettype wire

/* src/line_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module line_buf #(
    parameter  int LINE_PIX = 1024,
    localparam int ADDR_W   = $clog2(LINE_PIX)
) (
    input  logic                wr_clk,
    input  logic                wr_en,
    input  logic [ADDR_W-1:0]   wr_addr,
    input  combine_pkg::pix_t   wr_data,
    input  logic                rd_clk,
    input  logic [ADDR_W-1:0]   rd_addr,
    output combine_pkg::pix_t   rd_data
);

    import combine_pkg::*;

    pix_t mem [LINE_PIX];

    // Pixel clock side.
    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, one rclk of latency.
    always_ff @(posedge rd_clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule : line_buf

`default_nettype wire

/* src/line_wr_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module line_wr_ctrl #(
    parameter  int LINE_PIX = 1024,
    localparam int ADDR_W   = $clog2(LINE_PIX),
    localparam int PTR_W    = ADDR_W + 1
) (
    input  logic              pclk,
    input  logic              arst_n,
    input  logic              enable,
    input  logic              inited,
    input  logic              href,
    output logic              wr_en,
    output logic [ADDR_W-1:0] wr_addr,
    output logic [PTR_W-1:0]  wr_ptr_gray
);

    logic             en_meta;
    logic             en_sync;
    logic [PTR_W-1:0] ptr_bin;
    logic [PTR_W-1:0] ptr_next;

    // Enable comes from the rclk register block.
    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            en_meta <= 1'b0;
            en_sync <= 1'b0;
        end else begin
            en_meta <= enable;
            en_sync <= en_meta;
        end
    end

    assign wr_en    = href & inited & en_sync;
    assign ptr_next = ptr_bin + 1'b1;
    assign wr_addr  = ptr_bin[ADDR_W-1:0]; // Wraps with the buffer.

    // Gray copy tracks the binary pointer, one bit changes per write.
    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            ptr_bin     <= '0;
            wr_ptr_gray <= '0;
        end else if (wr_en) begin
            ptr_bin     <= ptr_next;
            wr_ptr_gray <= ptr_next ^ (ptr_next >> 1);
        end
    end

endmodule : line_wr_ctrl

`default_nettype wire

/* src/combine_pkg.sv */
`default_nettype none

package combine_pkg;

    // One camera pixel.
    typedef logic [15:0] pix_t;

    // Output pair, camera 1 in the upper half.
    typedef struct packed {
        pix_t pixel_1;
        pix_t pixel_2;
    } pix_pair_t;

    typedef logic [1:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;

    // Host command, held steady while req is high.
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        reg_data_t wdata;
    } host_req_t;

    // Register map.
    localparam reg_addr_t REG_CTRL     = 2'd0; // Bit 0 is enable.
    localparam reg_addr_t REG_LINE_LEN = 2'd1; // Zero disables finish.
    localparam reg_addr_t REG_LINE_CNT = 2'd2; // Write clears.

endpackage : combine_pkg

`default_nettype wire
